//--- flist.f
hw/mmio_map_pkg.sv
hw/wb_pkg.sv
hw/address_decoder.sv
hw/keypad_register.sv
hw/wishbone_manager.sv
hw/ack_center.sv
hw/mmio.sv
hw/wb_sram.sv
hw/mmio_top.sv
testbench/mmio_asserts.sv
testbench/mmio_tb.sv

//--- hw/ack_center.sv
`default_nettype none

module ack_center (
    input  mmio_map_pkg::region_t region,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic                  ram_done,
    input  logic                  display_ack,
    output logic                  d_ack,
    output logic                  i_ack,
    output logic                  key_read_done
);
    import mmio_map_pkg::*;

    logic access;

    assign access = mem_read | mem_write;

    always_comb begin
        d_ack = 1'b0;
        i_ack = 1'b0;
        case (region)
            region_ram: begin
                d_ack = ram_done;
                i_ack = ram_done & mem_read;
            end
            // Display reads complete at once with the unmapped word
            region_display: d_ack = mem_write ? display_ack : mem_read;
            default:        d_ack = access;
        endcase
    end

    assign key_read_done = (region == region_key) & mem_read & d_ack;

endmodule

`default_nettype wire

//--- hw/address_decoder.sv
`default_nettype none

module address_decoder (
    input  mmio_map_pkg::addr_t   address,
    input  logic                  mem_read,
    input  logic                  mem_write,
    output logic                  ram_en,
    output logic                  key_en,
    output logic                  wen,
    output mmio_map_pkg::region_t region
);
    import mmio_map_pkg::*;

    logic access;
    logic in_ram;
    logic in_key;
    logic in_display;

    assign access = mem_read | mem_write;

    // Window compares against the map
    assign in_ram     = (address >= ram_base) && (address <= ram_last);
    assign in_key     = (address == key_addr);
    assign in_display = (address >= display_base) && (address <= display_last);

    assign ram_en = in_ram & access;
    // Keypad is read only
    assign key_en = in_key & mem_read;
    assign wen    = in_display & mem_write;

    always_comb begin
        if (in_ram) begin
            region = region_ram;
        end else if (in_key) begin
            region = region_key;
        end else if (in_display) begin
            region = region_display;
        end else begin
            region = region_none;
        end
    end

endmodule

`default_nettype wire

//--- hw/keypad_register.sv
`default_nettype none

module keypad_register (
    input  logic                  clk,
    input  logic                  reset,
    input  mmio_map_pkg::button_t button_pressed,
    input  mmio_map_pkg::app_t    app,
    input  logic                  rising,
    input  logic                  key_read_done,
    output mmio_map_pkg::word_t   data_out
);
    import mmio_map_pkg::*;

    button_t button_q;
    app_t    app_q;
    logic    valid_q;

    // A new strobe wins over a read in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (rising) begin
            valid_q <= 1'b1;
        end else if (key_read_done) begin
            valid_q <= 1'b0;
        end
    end

    // Key fields only change on a strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            button_q <= '0;
            app_q    <= '0;
        end else if (rising) begin
            button_q <= button_pressed;
            app_q    <= app;
        end
    end

    // Valid bit on top with app above button
    always_comb begin
        data_out                = '0;
        data_out[4:0]           = button_q;
        data_out[6:5]           = app_q;
        data_out[key_valid_bit] = valid_q;
    end

endmodule

`default_nettype wire

//--- hw/mmio.sv
`default_nettype none

module mmio (
    input  logic                  clk,
    input  logic                  reset,

    // CPU
    input  mmio_map_pkg::addr_t   final_address,
    input  mmio_map_pkg::word_t   mem_store,
    input  logic                  mem_read,
    input  logic                  mem_write,
    output logic                  i_ack,
    output logic                  d_ack,
    output mmio_map_pkg::word_t   instruction,
    output mmio_map_pkg::word_t   memload,

    // Keypad
    input  mmio_map_pkg::button_t button_pressed,
    input  mmio_map_pkg::app_t    app,
    input  logic                  rising,

    // Display
    output mmio_map_pkg::addr_t   display_address,
    output mmio_map_pkg::word_t   mem_store_display,
    input  logic                  d_ack_display,
    output logic                  wen,

    // Wishbone to the RAM
    output wb_pkg::wb_addr_t      wb_adr,
    output mmio_map_pkg::word_t   wb_dat_w,
    output wb_pkg::wb_sel_t       wb_sel,
    output logic                  wb_we,
    output logic                  wb_stb,
    output logic                  wb_cyc,
    input  logic                  wb_ack,
    input  mmio_map_pkg::word_t   wb_dat_r
);
    import mmio_map_pkg::*;

    logic    ram_en;
    logic    key_en;
    logic    ram_done;
    logic    key_read_done;
    region_t region;
    word_t   ram_data;
    word_t   key_data;

    address_decoder decoder0 (
        .address   (final_address),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .ram_en    (ram_en),
        .key_en    (key_en),
        .wen       (wen),
        .region    (region)
    );

    // Only RAM-window requests reach the bus
    wishbone_manager manager0 (
        .clk       (clk),
        .reset     (reset),
        .read_req  (mem_read & ram_en),
        .write_req (mem_write & ram_en),
        .address   (final_address),
        .cpu_dat_w (mem_store),
        .cpu_dat_r (ram_data),
        .done      (ram_done),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_sel    (wb_sel),
        .wb_we     (wb_we),
        .wb_stb    (wb_stb),
        .wb_cyc    (wb_cyc),
        .wb_ack    (wb_ack),
        .wb_dat_r  (wb_dat_r)
    );

    keypad_register keypad0 (
        .clk            (clk),
        .reset          (reset),
        .button_pressed (button_pressed),
        .app            (app),
        .rising         (rising),
        .key_read_done  (key_read_done),
        .data_out       (key_data)
    );

    ack_center ack0 (
        .region        (region),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .ram_done      (ram_done),
        .display_ack   (d_ack_display),
        .d_ack         (d_ack),
        .i_ack         (i_ack),
        .key_read_done (key_read_done)
    );

    // Load data select
    always_comb begin
        if (ram_en) begin
            memload = ram_data;
        end else if (key_en) begin
            memload = key_data;
        end else begin
            memload = unmapped_word;
        end
    end

    assign instruction       = memload;
    assign display_address   = final_address;
    assign mem_store_display = mem_store;

endmodule

`default_nettype wire

//--- hw/mmio_map_pkg.sv
`default_nettype none

package mmio_map_pkg;

    // CPU side widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  button_t;
    typedef logic [1:0]  app_t;

    typedef enum logic [1:0] {
        region_ram,
        region_key,
        region_display,
        region_none
    } region_t;

    // Address map
    localparam addr_t ram_base      = 32'h0000_0000;
    localparam addr_t ram_last      = 32'h0000_03FF;
    localparam addr_t key_addr      = 32'h0000_8000;
    localparam addr_t display_base  = 32'h0000_9000;
    localparam addr_t display_last  = 32'h0000_90FF;

    // Value returned for reads that hit nothing
    localparam word_t unmapped_word  = 32'hDEADBEEF;
    localparam int    key_valid_bit  = 31;
    localparam int    ram_words      = 256;
    localparam int    ram_index_bits = $clog2(ram_words);

endpackage

`default_nettype wire

//--- hw/mmio_top.sv
`default_nettype none

module mmio_top (
    input  logic                  clk,
    input  logic                  reset,
    input  mmio_map_pkg::addr_t   final_address,
    input  mmio_map_pkg::word_t   mem_store,
    input  logic                  mem_read,
    input  logic                  mem_write,
    output logic                  i_ack,
    output logic                  d_ack,
    output mmio_map_pkg::word_t   instruction,
    output mmio_map_pkg::word_t   memload,
    input  mmio_map_pkg::button_t button_pressed,
    input  mmio_map_pkg::app_t    app,
    input  logic                  rising,
    output mmio_map_pkg::addr_t   display_address,
    output mmio_map_pkg::word_t   mem_store_display,
    input  logic                  d_ack_display,
    output logic                  wen
);
    import mmio_map_pkg::*;
    import wb_pkg::*;

    // Bus between the I/O block and the RAM
    wb_addr_t wb_adr;
    word_t    wb_dat_w;
    word_t    wb_dat_r;
    wb_sel_t  wb_sel;
    logic     wb_we;
    logic     wb_stb;
    logic     wb_cyc;
    logic     wb_ack;

    mmio mmio0 (
        .clk               (clk),
        .reset             (reset),
        .final_address     (final_address),
        .mem_store         (mem_store),
        .mem_read          (mem_read),
        .mem_write         (mem_write),
        .i_ack             (i_ack),
        .d_ack             (d_ack),
        .instruction       (instruction),
        .memload           (memload),
        .button_pressed    (button_pressed),
        .app               (app),
        .rising            (rising),
        .display_address   (display_address),
        .mem_store_display (mem_store_display),
        .d_ack_display     (d_ack_display),
        .wen               (wen),
        .wb_adr            (wb_adr),
        .wb_dat_w          (wb_dat_w),
        .wb_sel            (wb_sel),
        .wb_we             (wb_we),
        .wb_stb            (wb_stb),
        .wb_cyc            (wb_cyc),
        .wb_ack            (wb_ack),
        .wb_dat_r          (wb_dat_r)
    );

    wb_sram sram0 (
        .clk      (clk),
        .reset    (reset),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_we    (wb_we),
        .wb_stb   (wb_stb),
        .wb_cyc   (wb_cyc),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r)
    );

endmodule

`default_nettype wire

//--- hw/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // Bus address and byte selects
    typedef logic [31:0] wb_addr_t;
    typedef logic [3:0]  wb_sel_t;

    // Manager cycle states
    typedef enum logic [1:0] {
        mgr_idle,
        mgr_bus,
        mgr_done
    } mgr_state_t;

endpackage

`default_nettype wire

//--- hw/wb_sram.sv
`default_nettype none

module wb_sram (
    input  logic                clk,
    input  logic                reset,
    input  wb_pkg::wb_addr_t    wb_adr,
    input  mmio_map_pkg::word_t wb_dat_w,
    input  wb_pkg::wb_sel_t     wb_sel,
    input  logic                wb_we,
    input  logic                wb_stb,
    input  logic                wb_cyc,
    output logic                wb_ack,
    output mmio_map_pkg::word_t wb_dat_r
);
    import mmio_map_pkg::*;

    word_t                     mem [ram_words];
    logic [ram_index_bits-1:0] index;
    logic                      access;

    // Word address from the byte address
    assign index = wb_adr[ram_index_bits+1:2];

    // Held ack blocks a second answer to the same cycle
    assign access = wb_cyc & wb_stb & ~wb_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (wb_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_sel[b]) begin
                        mem[index][8*b +: 8] <= wb_dat_w[8*b +: 8];
                    end
                end
            end
            wb_dat_r <= mem[index];
        end
    end

endmodule

`default_nettype wire

//--- hw/wishbone_manager.sv
`default_nettype none

module wishbone_manager (
    input  logic                clk,
    input  logic                reset,
    input  logic                read_req,
    input  logic                write_req,
    input  mmio_map_pkg::addr_t address,
    input  mmio_map_pkg::word_t cpu_dat_w,
    output mmio_map_pkg::word_t cpu_dat_r,
    output logic                done,
    output wb_pkg::wb_addr_t    wb_adr,
    output mmio_map_pkg::word_t wb_dat_w,
    output wb_pkg::wb_sel_t     wb_sel,
    output logic                wb_we,
    output logic                wb_stb,
    output logic                wb_cyc,
    input  logic                wb_ack,
    input  mmio_map_pkg::word_t wb_dat_r
);
    import wb_pkg::*;

    mgr_state_t state;
    mgr_state_t state_next;
    logic       start;

    assign start = (state == mgr_idle) && (read_req || write_req);

    always_comb begin
        state_next = state;
        case (state)
            mgr_idle: begin
                if (read_req || write_req) begin
                    state_next = mgr_bus;
                end
            end
            mgr_bus: begin
                if (wb_ack) begin
                    state_next = mgr_done;
                end
            end
            // One cycle of done and back to idle whatever the request
            mgr_done: state_next = mgr_idle;
            default:  state_next = mgr_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mgr_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_we <= 1'b0;
        end else if (start) begin
            wb_we <= write_req;
        end
    end

    // Address and store data captured once per cycle
    always_ff @(posedge clk) begin
        if (start) begin
            wb_adr   <= address;
            wb_dat_w <= cpu_dat_w;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == mgr_bus) && wb_ack && !wb_we) begin
            cpu_dat_r <= wb_dat_r;
        end
    end

    // Full word accesses only
    assign wb_sel = 4'hF;
    assign wb_cyc = (state == mgr_bus);
    assign wb_stb = (state == mgr_bus);
    assign done   = (state == mgr_done);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module mmio_tb -f flist.f -o mmio_sim \
    && ./obj_dir/mmio_sim > sim.log 2>&1 \
    || echo "sim failed" >> sim.log
if grep -q "sim failed" sim.log; then
    echo "Simulation FAILED, see sim.log"
    exit 1
fi
echo "Simulation PASSED"
exit 0

//--- testbench/mmio_asserts.sv
`default_nettype none

module mmio_asserts (
    input logic clk,
    input logic reset,
    input logic i_ack,
    input logic d_ack,
    input logic wen,
    input logic mem_write,
    input logic wb_stb,
    input logic wb_ack
);

    // Instruction ack only ever rides on a data ack
    iack_with_dack: assert property (@(posedge clk) disable iff (reset) i_ack |-> d_ack)
        else $error("i_ack high without d_ack");

    wen_with_write: assert property (@(posedge clk) disable iff (reset) wen |-> mem_write)
        else $error("wen high without mem_write");

    // Classic cycle holds the strobe until the subordinate answers
    stb_until_ack: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=> wb_stb)
        else $error("wb_stb dropped before wb_ack");

endmodule

bind mmio mmio_asserts asserts0 (
    .clk       (clk),
    .reset     (reset),
    .i_ack     (i_ack),
    .d_ack     (d_ack),
    .wen       (wen),
    .mem_write (mem_write),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack)
);

`default_nettype wire

//--- testbench/mmio_tb.sv
`default_nettype none

module mmio_tb;
    import mmio_map_pkg::*;

    localparam int          cycle_limit = 2000;
    localparam logic [31:0] seed        = 32'h1cab5544;
    localparam int          ram_tests   = 12;

    logic    clk;
    logic    reset;
    addr_t   final_address;
    word_t   mem_store;
    logic    mem_read;
    logic    mem_write;
    logic    i_ack;
    logic    d_ack;
    word_t   instruction;
    word_t   memload;
    button_t button_pressed;
    app_t    app;
    logic    rising;
    addr_t   display_address;
    word_t   mem_store_display;
    logic    d_ack_display;
    logic    wen;

    // Shadow state of the memory map
    word_t   shadow_ram [ram_words];
    logic    shadow_valid;
    button_t shadow_button;
    app_t    shadow_app;

    string   current_test;
    int      error_count = 0;
    int      check_count = 0;
    int      test_count = 0;
    int      test_errors_base = 0;
    int      cycle_count = 0;
    int      held_cycles = 0;
    int      display_delay;
    logic [31:0] r;
    addr_t   addr;
    addr_t   written [$];

    mmio_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Expected load word from the region rules
    function automatic word_t expected_load(input addr_t a);
        word_t key_word;
        if (a <= ram_last) begin
            return shadow_ram[a[9:2]];
        end
        if (a == key_addr) begin
            key_word      = '0;
            key_word[4:0] = shadow_button;
            key_word[6:5] = shadow_app;
            key_word[31]  = shadow_valid;
            return key_word;
        end
        // Display reads and holes
        return unmapped_word;
    endfunction

    function automatic word_t bit_word(input logic b);
        return {31'd0, b};
    endfunction

    task automatic check_value(input string what, input word_t expected, input word_t actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("** Error %s %s: expected %h, actual %h",
                     current_test, what, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        current_test     = name;
        test_errors_base = error_count;
    endtask

    task automatic end_test();
        test_count++;
        $display("test %-8s done, %0d errors", current_test, error_count - test_errors_base);
    endtask

    // CPU model holding the request until d_ack
    task automatic cpu_access(input logic write, input addr_t a, input word_t data);
        @(negedge clk);
        final_address = a;
        mem_store     = data;
        mem_write     = write;
        mem_read      = ~write;
        @(posedge clk);
        while (!d_ack) begin
            @(posedge clk);
        end
        @(negedge clk);
        mem_read  = 1'b0;
        mem_write = 1'b0;
        if (write && a <= ram_last) begin
            shadow_ram[a[9:2]] = data;
        end
        if (!write && a == key_addr) begin
            shadow_valid = 1'b0;
        end
    endtask

    // Display controller answers after 1 to 5 cycles
    initial begin
        d_ack_display = 1'b0;
        forever begin
            @(posedge clk);
            if (wen) begin
                display_delay = $urandom_range(5, 1);
                repeat (display_delay) @(negedge clk);
                d_ack_display = 1'b1;
                @(negedge clk);
                d_ack_display = 1'b0;
            end
        end
    end

    // Compare process
    always @(posedge clk) begin
        if (!reset) begin
            if (mem_read || mem_write) begin
                if (d_ack && mem_read) begin
                    check_value("memload", expected_load(final_address), memload);
                    check_value("instruction", expected_load(final_address), instruction);
                end
                check_value("i_ack",
                            bit_word(mem_read && final_address <= ram_last
                                     && held_cycles == 3),
                            bit_word(i_ack));
                if (mem_write && final_address >= display_base
                        && final_address <= display_last) begin
                    check_value("d_ack", bit_word(d_ack_display), bit_word(d_ack));
                    check_value("wen", 32'd1, bit_word(wen));
                    check_value("display_address", final_address, display_address);
                    check_value("mem_store_display", mem_store, mem_store_display);
                end else begin
                    check_value("wen", 32'd0, bit_word(wen));
                    if (d_ack) begin
                        // RAM takes 3 cycles and everything else acks at once
                        check_value("latency", (final_address <= ram_last) ? 32'd3 : 32'd0,
                                    word_t'(held_cycles));
                    end
                end
                held_cycles++;
            end else begin
                check_value("idle d_ack", 32'd0, bit_word(d_ack));
                check_value("idle i_ack", 32'd0, bit_word(i_ack));
                check_value("idle wen", 32'd0, bit_word(wen));
                check_value("idle wb_cyc", 32'd0, bit_word(dut0.wb_cyc));
                held_cycles = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(seed));
        reset          = 1'b1;
        final_address  = '0;
        mem_store      = '0;
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        button_pressed = '0;
        app            = '0;
        rising         = 1'b0;
        shadow_valid   = 1'b0;
        shadow_button  = '0;
        shadow_app     = '0;

        start_test("reset");
        repeat (4) @(negedge clk);
        reset = 1'b0;
        repeat (3) @(negedge clk);
        end_test();

        start_test("ram");
        for (int i = 0; i < ram_tests; i++) begin
            r    = $urandom_range(ram_words - 1, 0);
            addr = {22'd0, r[7:0], 2'b00};
            written.push_back(addr);
            cpu_access(1'b1, addr, $urandom());
        end
        foreach (written[i]) begin
            cpu_access(1'b0, written[i], 32'd0);
        end
        end_test();

        start_test("keypad");
        @(negedge clk);
        r              = $urandom();
        button_pressed = r[4:0];
        app            = r[6:5];
        rising         = 1'b1;
        @(negedge clk);
        rising        = 1'b0;
        shadow_button = button_pressed;
        shadow_app    = app;
        shadow_valid  = 1'b1;
        cpu_access(1'b0, key_addr, 32'd0);
        // Second read sees the flag cleared
        cpu_access(1'b0, key_addr, 32'd0);
        end_test();

        start_test("display");
        for (int i = 0; i < 4; i++) begin
            r = $urandom();
            cpu_access(1'b1, display_base + {24'd0, r[7:2], 2'b00}, $urandom());
        end
        end_test();

        start_test("unmapped");
        cpu_access(1'b0, 32'h0000_1000, 32'd0);
        cpu_access(1'b0, 32'h0000_8004, 32'd0);
        cpu_access(1'b0, 32'hFFFF_FFFC, 32'd0);
        cpu_access(1'b0, display_base + 32'h10, 32'd0);
        cpu_access(1'b1, 32'h0000_4000, $urandom());
        end_test();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
